// File: sim.f
+incdir+src
src/fe_pkg.sv
src/fe_pc_gen.sv
src/fe_imem.sv
src/fe_control.sv
src/fe_fetch_stage.sv
src/fe_top.sv
verification/fe_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sim.f --top-module fe_tb -Mdir obj_dir -o fe_tb_sim
./obj_dir/fe_tb_sim

// File: verification/fe_tb.sv
//**************************************************************************
// Directed testbench for the instruction fetch front end. Loads the
// instruction memory with pseudo-random words, keeps a model copy and
// checks every queue message against it. Stops at the first error.
//**************************************************************************

`timescale 1ns/1ps

`include "fe_cfg.svh"

module fe_tb
  import fe_pkg::*;
;

  localparam int MSG_TIMEOUT = 50;

  typedef logic [$bits(fe_queue_s)-1:0] chk_t;

  logic      clk_i;
  logic      reset_i;
  fe_cmd_s   fe_cmd;
  logic      fe_cmd_v;
  logic      fe_cmd_yumi;
  fe_queue_s fe_queue;
  logic      fe_queue_v;
  logic      fe_queue_ready;
  imem_wr_s  imem_wr;
  logic      imem_wr_v;

  instr_t      model_mem [`FE_IMEM_DEPTH];
  logic [15:0] lfsr_state;
  int          drop_left;

  fe_top dut_i (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .fe_cmd_i         (fe_cmd),
    .fe_cmd_v_i       (fe_cmd_v),
    .fe_cmd_yumi_o    (fe_cmd_yumi),
    .fe_queue_o       (fe_queue),
    .fe_queue_v_o     (fe_queue_v),
    .fe_queue_ready_i (fe_queue_ready),
    .imem_wr_i        (imem_wr),
    .imem_wr_v_i      (imem_wr_v)
  );

  always #5 clk_i = ~clk_i;

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  task automatic rand_bits(input int nbits, output logic [31:0] value);
    value = '0;
    for (int b = 0; b < nbits; b++) begin
      value = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  function automatic fe_queue_s fetch_msg(input vaddr_t pc);
    fe_queue_s msg;
    msg          = '0;
    msg.msg_type = e_fe_fetch;
    msg.pc       = pc;
    msg.instr    = model_mem[imem_idx_t'(pc >> 2)];
    return msg;
  endfunction

  function automatic fe_queue_s exc_msg(input vaddr_t pc, input fe_exc_code_e code);
    fe_queue_s msg;
    msg          = '0;
    msg.msg_type = e_fe_exception;
    msg.pc       = pc;
    msg.exc_code = code;
    return msg;
  endfunction

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_value(input chk_t actual, input chk_t expected, input string what);
    if (actual !== expected) begin
      fail_run($sformatf("CHECK FAILED at %0t: %s: got %0h, expected %0h",
                         $time, what, actual, expected));
    end
  endtask

  task automatic next_cycle();
    @(posedge clk_i);
    #1;
  endtask

  // ready drops for 1 to 4 cycles, about one cycle in four
  task automatic update_ready();
    logic [31:0] r;
    if (drop_left != 0) begin
      fe_queue_ready = 1'b0;
      drop_left = drop_left - 1;
    end else begin
      rand_bits(2, r);
      if (r[1:0] == 2'd0) begin
        fe_queue_ready = 1'b0;
        rand_bits(2, r);
        drop_left = int'(r[1:0]);
      end else begin
        fe_queue_ready = 1'b1;
      end
    end
  endtask

  task automatic send_cmd(input fe_opcode_e op, input vaddr_t addr);
    fe_cmd.opcode = op;
    fe_cmd.vaddr  = addr;
    fe_cmd_v      = 1'b1;
    @(negedge clk_i);
    check_value(chk_t'(fe_cmd_yumi), chk_t'(1), "command taken in its valid cycle");
    check_value(chk_t'(fe_queue_v), chk_t'(0), "no message in command cycle");
    next_cycle();
    fe_cmd_v = 1'b0;
  endtask

  task automatic wait_msg(input logic random_ready, output fe_queue_s msg);
    logic got;
    int   n;
    got = 1'b0;
    msg = '0;
    for (n = 0; n < MSG_TIMEOUT && !got; n++) begin
      @(negedge clk_i);
      if (fe_queue_v) begin
        msg = fe_queue;
        got = 1'b1;
      end
      next_cycle();
      if (random_ready) begin
        update_ready();
      end
    end
    if (!got) begin
      fail_run("timed out waiting for a message on the queue output");
    end
  endtask

  task automatic expect_stream(input vaddr_t start_pc, input int count,
                               input logic random_ready);
    fe_queue_s msg;
    vaddr_t    pc;
    pc = start_pc;
    for (int k = 0; k < count; k++) begin
      wait_msg(random_ready, msg);
      check_value(msg, fetch_msg(pc), $sformatf("fetch message for pc %0h", pc));
      pc = pc + 32'd4;
    end
  endtask

  task automatic expect_quiet(input int cycles, input string what);
    for (int k = 0; k < cycles; k++) begin
      @(negedge clk_i);
      check_value(chk_t'(fe_queue_v), chk_t'(0), what);
      next_cycle();
    end
  endtask

  task automatic apply_reset();
    reset_i = 1'b1;
    for (int k = 0; k < 10; k++) begin
      next_cycle();
      check_value(chk_t'(fe_queue_v), chk_t'(0), "queue idle during reset");
    end
    reset_i = 1'b0;
  endtask

  task automatic load_memory();
    logic [31:0] w;
    for (int i = 0; i < `FE_IMEM_DEPTH; i++) begin
      rand_bits(32, w);
      model_mem[imem_idx_t'(i)] = w;
      imem_wr.idx  = imem_idx_t'(i);
      imem_wr.data = w;
      imem_wr_v    = 1'b1;
      next_cycle();
    end
    imem_wr_v = 1'b0;
  endtask

  task automatic test_idle_after_reset();
    expect_quiet(20, "no fetch before the first command");
  endtask

  task automatic test_sequential_fetch();
    send_cmd(e_op_pc_redirect, 32'h40);
    expect_stream(32'h40, 16, 1'b0);
  endtask

  // continues the stream left running by the sequential test
  task automatic test_backpressure();
    drop_left = 0;
    expect_stream(32'h80, 24, 1'b1);
    fe_queue_ready = 1'b1;
  endtask

  task automatic test_state_reset();
    send_cmd(e_op_state_reset, 32'h200);
    expect_stream(32'h200, 8, 1'b0);
  endtask

  task automatic test_access_fault();
    fe_queue_s msg;
    send_cmd(e_op_pc_redirect, 32'h3F0);
    expect_stream(32'h3F0, 4, 1'b0);
    wait_msg(1'b0, msg);
    check_value(msg, exc_msg(32'h400, e_instr_access_fault), "access fault message");
    expect_quiet(20, "front end waits after access fault");
  endtask

  task automatic test_misaligned_and_wait();
    fe_queue_s msg;
    send_cmd(e_op_pc_redirect, 32'h102);
    wait_msg(1'b0, msg);
    check_value(msg, exc_msg(32'h102, e_instr_misaligned), "misaligned message");
    expect_quiet(10, "single misaligned exception");
    send_cmd(e_op_wait, 32'h80);
    expect_stream(32'h80, 4, 1'b0);
  endtask

  initial begin
    clk_i          = 1'b0;
    reset_i        = 1'b1;
    fe_cmd         = '0;
    fe_cmd_v       = 1'b0;
    fe_queue_ready = 1'b1;
    imem_wr        = '0;
    imem_wr_v      = 1'b0;
    lfsr_state     = 16'd49749;
    drop_left      = 0;

    apply_reset();
    load_memory();
    test_idle_after_reset();
    test_sequential_fetch();
    test_backpressure();
    test_state_reset();
    test_access_fault();
    test_misaligned_and_wait();

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: src/fe_top.sv
//**************************************************************************
// Instruction fetch front end. Takes commands from the back end, fetches
// from the on-chip instruction memory and sends fetch or exception
// messages to the back-end queue. The memory is loaded via imem_wr_i.
//**************************************************************************

`timescale 1ns/1ps

module fe_top
  import fe_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  fe_cmd_s   fe_cmd_i,
  input  logic      fe_cmd_v_i,
  output logic      fe_cmd_yumi_o,

  output fe_queue_s fe_queue_o,
  output logic      fe_queue_v_o,
  input  logic      fe_queue_ready_i,

  input  imem_wr_s  imem_wr_i,
  input  logic      imem_wr_v_i
);

  logic   redirect_v;
  vaddr_t redirect_pc;
  logic   next_pc_yumi;
  vaddr_t next_pc;
  instr_t instr;
  logic   misaligned;
  logic   access_fault;
  vaddr_t fetch_pc;
  logic   fetch_fail;
  logic   fetch_exception;
  logic   cmd_flush;

  fe_control control_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .fe_cmd_i          (fe_cmd_i),
    .fe_cmd_v_i        (fe_cmd_v_i),
    .fe_cmd_yumi_o     (fe_cmd_yumi_o),
    .fe_queue_ready_i  (fe_queue_ready_i),
    .fetch_pc_i        (fetch_pc),
    .fetch_fail_i      (fetch_fail),
    .fetch_exception_i (fetch_exception),
    .redirect_v_o      (redirect_v),
    .redirect_pc_o     (redirect_pc),
    .next_pc_yumi_o    (next_pc_yumi),
    .cmd_flush_o       (cmd_flush)
  );

  fe_pc_gen pc_gen_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .redirect_v_i   (redirect_v),
    .redirect_pc_i  (redirect_pc),
    .next_pc_yumi_i (next_pc_yumi),
    .next_pc_o      (next_pc)
  );

  fe_imem imem_i (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .wr_i           (imem_wr_i),
    .wr_v_i         (imem_wr_v_i),
    .rd_v_i         (next_pc_yumi),
    .rd_pc_i        (next_pc),
    .instr_o        (instr),
    .misaligned_o   (misaligned),
    .access_fault_o (access_fault)
  );

  fe_fetch_stage fetch_stage_i (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .next_pc_yumi_i    (next_pc_yumi),
    .next_pc_i         (next_pc),
    .instr_i           (instr),
    .misaligned_i      (misaligned),
    .access_fault_i    (access_fault),
    .cmd_flush_i       (cmd_flush),
    .fe_queue_ready_i  (fe_queue_ready_i),
    .fe_queue_o        (fe_queue_o),
    .fe_queue_v_o      (fe_queue_v_o),
    .fetch_pc_o        (fetch_pc),
    .fetch_fail_o      (fetch_fail),
    .fetch_exception_o (fetch_exception)
  );

endmodule

// File: src/fe_fetch_stage.sv
//**************************************************************************
// Two-stage fetch pipeline. IF1 follows the memory read, IF2 holds the
// fetched word with its fault flags and presents a fetch or exception
// message to the queue. A failed send, an exception or a command poisons
// the younger fetch in IF1.
//**************************************************************************

`timescale 1ns/1ps

module fe_fetch_stage
  import fe_pkg::*;
(
  input  logic      clk_i,
  input  logic      reset_i,

  input  logic      next_pc_yumi_i,
  input  vaddr_t    next_pc_i,

  input  instr_t    instr_i,
  input  logic      misaligned_i,
  input  logic      access_fault_i,

  input  logic      cmd_flush_i,

  input  logic      fe_queue_ready_i,
  output fe_queue_s fe_queue_o,
  output logic      fe_queue_v_o,

  output vaddr_t    fetch_pc_o,
  output logic      fetch_fail_o,
  output logic      fetch_exception_o
);

  logic   v_if1_r, v_if2_r;
  logic   v_if2_n;
  vaddr_t pc_if1_r, pc_if2_r;
  instr_t instr_if2_r;
  logic   misaligned_if2_r, access_fault_if2_r;
  logic   fault_if2;
  logic   poison_if1;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_if1_r <= 1'b0;
      v_if2_r <= 1'b0;
    end else begin
      v_if1_r <= next_pc_yumi_i;
      v_if2_r <= v_if2_n;
    end
  end

  always_ff @(posedge clk_i) begin
    if (next_pc_yumi_i) begin
      pc_if1_r <= next_pc_i;
    end
  end

  // IF2 payload and fault register
  always_ff @(posedge clk_i) begin
    if (v_if2_n) begin
      pc_if2_r           <= pc_if1_r;
      instr_if2_r        <= instr_i;
      misaligned_if2_r   <= misaligned_i;
      access_fault_if2_r <= access_fault_i;
    end
  end

  assign fault_if2 = misaligned_if2_r | access_fault_if2_r;

  assign fe_queue_v_o      = fe_queue_ready_i & v_if2_r & ~cmd_flush_i;
  assign fetch_fail_o      = v_if2_r & ~fe_queue_v_o;
  assign fetch_exception_o = fe_queue_v_o & fault_if2;
  assign fetch_pc_o        = pc_if2_r;

  assign poison_if1 = fetch_fail_o | (v_if2_r & fault_if2) | cmd_flush_i;
  assign v_if2_n    = v_if1_r & ~poison_if1;

  // access fault outranks misaligned
  always_comb begin
    fe_queue_o    = '0;
    fe_queue_o.pc = pc_if2_r;
    if (fault_if2) begin
      fe_queue_o.msg_type = e_fe_exception;
      fe_queue_o.exc_code = access_fault_if2_r ? e_instr_access_fault : e_instr_misaligned;
    end else begin
      fe_queue_o.msg_type = e_fe_fetch;
      fe_queue_o.instr    = instr_if2_r;
    end
  end

  // nothing younger than a faulting fetch is sent
  a_exc_ends_stream: assert property (
    @(posedge clk_i) disable iff (reset_i)
    (fe_queue_v_o && fault_if2) |=> !fe_queue_v_o
  ) else $error("message right after an exception");

  // a failed send empties IF2, nothing stale may follow it
  a_fail_drains: assert property (
    @(posedge clk_i) disable iff (reset_i)
    fetch_fail_o |=> !fe_queue_v_o
  ) else $error("message right after fetch fail");

endmodule

// File: src/fe_control.sv
//**************************************************************************
// Front end controller. Decodes back-end commands, keeps the PC to
// resume from and runs the wait/run/stall state machine. Fetch of a new
// PC is allowed in every cycle whose next state is run.
//**************************************************************************

`timescale 1ns/1ps

`include "fe_cfg.svh"

module fe_control
  import fe_pkg::*;
(
  input  logic    clk_i,
  input  logic    reset_i,

  input  fe_cmd_s fe_cmd_i,
  input  logic    fe_cmd_v_i,
  output logic    fe_cmd_yumi_o,

  input  logic    fe_queue_ready_i,

  input  vaddr_t  fetch_pc_i,
  input  logic    fetch_fail_i,
  input  logic    fetch_exception_i,

  output logic    redirect_v_o,
  output vaddr_t  redirect_pc_o,
  output logic    next_pc_yumi_o,
  output logic    cmd_flush_o
);

  fe_state_e state_r, state_n;

  logic   is_wait, is_run, is_stall;
  logic   state_reset_v, pc_redirect_v, wait_v;
  logic   cmd_v, cmd_immediate_v, cmd_complex_v;
  logic   stall, unstall;
  logic   pc_resume_en;
  vaddr_t pc_resume_n, pc_resume_r;

  assign is_wait  = (state_r == e_wait);
  assign is_run   = (state_r == e_run);
  assign is_stall = (state_r == e_stall);

  // command decode
  assign state_reset_v   = fe_cmd_v_i & (fe_cmd_i.opcode == e_op_state_reset);
  assign pc_redirect_v   = fe_cmd_v_i & (fe_cmd_i.opcode == e_op_pc_redirect);
  assign wait_v          = fe_cmd_v_i & (fe_cmd_i.opcode == e_op_wait);
  assign cmd_immediate_v = pc_redirect_v;
  assign cmd_complex_v   = state_reset_v | wait_v;
  assign cmd_v           = cmd_immediate_v | cmd_complex_v;

  // every command is consumed on arrival
  assign fe_cmd_yumi_o = fe_cmd_v_i;
  assign cmd_flush_o   = cmd_v;

  // resume PC, bypassed so a redirect uses its vaddr in the same cycle
  assign pc_resume_en  = cmd_v | is_run;
  assign pc_resume_n   = cmd_v ? fe_cmd_i.vaddr : fetch_pc_i;
  assign redirect_pc_o = pc_resume_en ? pc_resume_n : pc_resume_r;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_resume_r <= `FE_BOOT_PC;
    end else if (pc_resume_en) begin
      pc_resume_r <= pc_resume_n;
    end
  end

  assign stall   = fetch_fail_i | cmd_complex_v;
  assign unstall = fe_queue_ready_i & ~cmd_v;

  always_comb begin
    case (state_r)
      e_wait:  state_n = cmd_immediate_v ? e_run : (cmd_complex_v ? e_stall : e_wait);
      e_stall: state_n = (cmd_immediate_v | unstall) ? e_run : e_stall;
      // a redirect keeps running, anything that failed goes back to stall
      e_run: begin
        if (cmd_immediate_v) begin
          state_n = e_run;
        end else if (stall) begin
          state_n = e_stall;
        end else if (fetch_exception_i) begin
          state_n = e_wait;
        end else begin
          state_n = e_run;
        end
      end
      default: state_n = e_wait;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r <= e_wait;
    end else begin
      state_r <= state_n;
    end
  end

  assign next_pc_yumi_o = (state_n == e_run);
  assign redirect_v_o   = cmd_immediate_v | (is_stall & next_pc_yumi_o);

  // the pipeline is empty whenever the front end is not running
  a_stall_drained: assert property (
    @(posedge clk_i) disable iff (reset_i)
    is_stall |-> !(fetch_fail_i || fetch_exception_i)
  ) else $error("fetch activity while stalled");

  a_wait_drained: assert property (
    @(posedge clk_i) disable iff (reset_i)
    is_wait |-> !(fetch_fail_i || fetch_exception_i)
  ) else $error("fetch activity while waiting");

endmodule

// File: src/fe_imem.sv
//**************************************************************************
// Word-addressed instruction memory. The environment loads it through
// the write port. A fetch read returns the word and its fault flags one
// cycle later, which is the IF1 result of the fetch pipeline.
//**************************************************************************

`timescale 1ns/1ps

`include "fe_cfg.svh"

module fe_imem
  import fe_pkg::*;
(
  input  logic     clk_i,
  input  logic     reset_i,

  input  imem_wr_s wr_i,
  input  logic     wr_v_i,

  input  logic     rd_v_i,
  input  vaddr_t   rd_pc_i,

  output instr_t   instr_o,
  output logic     misaligned_o,
  output logic     access_fault_o
);

  instr_t mem_r [`FE_IMEM_DEPTH];

  imem_idx_t                rd_idx;
  logic [`FE_VADDR_W-3:0]   word_addr;
  logic                     misaligned_n;
  logic                     access_fault_n;

  assign rd_idx    = rd_pc_i[`FE_IMEM_AW+1:2];
  assign word_addr = rd_pc_i[`FE_VADDR_W-1:2];

  // fault checks on the requested PC
  assign misaligned_n   = |rd_pc_i[1:0];
  assign access_fault_n = (word_addr >= (`FE_VADDR_W-2)'(`FE_IMEM_DEPTH));

  always_ff @(posedge clk_i) begin
    if (wr_v_i) begin
      mem_r[wr_i.idx] <= wr_i.data;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rd_v_i) begin
      instr_o <= mem_r[rd_idx];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      misaligned_o   <= 1'b0;
      access_fault_o <= 1'b0;
    end else if (rd_v_i) begin
      misaligned_o   <= misaligned_n;
      access_fault_o <= access_fault_n;
    end
  end

endmodule

// File: src/fe_pc_gen.sv
//**************************************************************************
// Next-PC generator. Holds the PC of the last accepted fetch and offers
// either the redirect target or the sequential successor. The offered
// PC is taken whenever the controller raises yumi.
//**************************************************************************

`timescale 1ns/1ps

`include "fe_cfg.svh"

module fe_pc_gen
  import fe_pkg::*;
(
  input  logic   clk_i,
  input  logic   reset_i,

  input  logic   redirect_v_i,
  input  vaddr_t redirect_pc_i,

  input  logic   next_pc_yumi_i,
  output vaddr_t next_pc_o
);

  vaddr_t pc_r;
  vaddr_t pc_plus4;

  assign pc_plus4 = pc_r + vaddr_t'(4);

  // redirect wins over sequential fetch
  always_comb begin
    if (redirect_v_i) begin
      next_pc_o = redirect_pc_i;
    end else begin
      next_pc_o = pc_plus4;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pc_r <= `FE_BOOT_PC;
    end else if (next_pc_yumi_i) begin
      pc_r <= next_pc_o;
    end
  end

  // a redirect target not taken in its cycle would be lost,
  // so the controller must always accept it
  a_redirect_taken: assert property (
    @(posedge clk_i) disable iff (reset_i)
    redirect_v_i |-> next_pc_yumi_i
  ) else $error("redirect without next_pc_yumi");

endmodule

// File: src/fe_pkg.sv
//**************************************************************************
// Shared types of the fetch front end: commands from the back end,
// queue messages toward it, memory load packets and the controller
// states. Import with a wildcard in the module header.
//**************************************************************************

`include "fe_cfg.svh"

package fe_pkg;

  typedef logic [`FE_VADDR_W-1:0] vaddr_t;
  typedef logic [`FE_INSTR_W-1:0] instr_t;
  typedef logic [`FE_IMEM_AW-1:0] imem_idx_t;

  typedef enum logic [1:0] {
    e_op_state_reset = 2'd0,
    e_op_pc_redirect = 2'd1,
    e_op_wait        = 2'd2
  } fe_opcode_e;

  typedef struct packed {
    fe_opcode_e opcode;
    vaddr_t     vaddr;
  } fe_cmd_s;

  typedef enum logic {
    e_fe_fetch     = 1'b0,
    e_fe_exception = 1'b1
  } fe_msg_type_e;

  // same numbering as the RISC-V cause codes
  typedef enum logic [1:0] {
    e_instr_misaligned   = 2'd0,
    e_instr_access_fault = 2'd1
  } fe_exc_code_e;

  typedef struct packed {
    fe_msg_type_e msg_type;
    vaddr_t       pc;
    instr_t       instr;
    fe_exc_code_e exc_code;
  } fe_queue_s;

  typedef struct packed {
    imem_idx_t idx;
    instr_t    data;
  } imem_wr_s;

  typedef enum logic [1:0] {
    e_wait  = 2'd0,
    e_run   = 2'd1,
    e_stall = 2'd2
  } fe_state_e;

endpackage

// File: src/fe_cfg.svh
//**************************************************************************
// Build-time constants for the instruction fetch front end.
// Include this header wherever a width, the memory size or the boot PC
// is needed. The package builds its types from these values.
//**************************************************************************

`ifndef FE_CFG_SVH
`define FE_CFG_SVH

// address and instruction widths
`define FE_VADDR_W 32
`define FE_INSTR_W 32

// on-chip instruction memory, in words
`define FE_IMEM_DEPTH 256
`define FE_IMEM_AW    8

`define FE_BOOT_PC 32'h0000_0000

`endif
